// File: rtl/rvcDecodePkg.sv
`default_nettype none

package rvcDecodePkg;

    localparam int InstrW  = 16;  // Compressed instruction width
    localparam int ImmW    = 32;
    localparam int RegSp   = 2;   // x2
    localparam int RegLink = 1;   // x1

    // Main opcode, {quadrant, funct3[2:1]}
    typedef enum logic [3:0] {
        OP_ADDI4SPN,              // 00,00
        OP_LW,                    // 00,01
        OP_BAD_2,                 // 00,10 no RV32C group here
        OP_SW,                    // 00,11
        OP_ADDI_NOP_JAL,          // 01,00
        OP_LI_LUI_ADDI16SP,       // 01,01
        OP_ALUMAIN_J,             // 01,10
        OP_BEQZ_BNEZ,             // 01,11
        OP_SLLI,                  // 10,00
        OP_LWSP,                  // 10,01
        OP_MV_JR_ADD_JALR_EBREAK, // 10,10
        OP_SWSP                   // 10,11
    } mainOpT;

    // One value per decoded instruction group
    typedef enum logic [4:0] {
        J, JAL, JR, JALR_EBREAK, BEQZ_BNEZ,
        LW, SW, LWSP, SWSP,
        ALUMAIN, ANDI, SRAI_SRLI, ADDI_NOP, SLLI, LI, LUI, MV, ADD,
        ADDI4SPN, ADDI16SP,
        ILLEGAL
    } instrClassT;

    typedef enum logic [1:0] {BITWISE = 2'd0, ADDSUB = 2'd1, SHIFT = 2'd2, FLAG = 2'd3} aluCatT;

    // ALU opcode, meaning set by the category
    typedef logic [1:0] aluOpT;
    localparam aluOpT BTXOR  = 2'd1;
    localparam aluOpT BTOR   = 2'd2;
    localparam aluOpT BTAND  = 2'd3;
    localparam aluOpT AFSUBS = 2'd0;  // Signed subtract
    localparam aluOpT AFADD  = 2'd1;
    localparam aluOpT AFSUBU = 2'd2;  // Unsigned subtract
    localparam aluOpT AFEQU  = 2'd3;
    localparam aluOpT SHSLL  = 2'd0;
    localparam aluOpT SHSRL  = 2'd2;
    localparam aluOpT SHSRA  = 2'd3;

    typedef enum logic [1:0] {PCINC = 2'd0, PCBRCH = 2'd1, PCJREG = 2'd2, PCJIMM = 2'd3} pcModeT;
    typedef enum logic [1:0] {LSN = 2'd0, LSW = 2'd1, LSH = 2'd2, LSB = 2'd3} lsuWidthT;

    // One row of the control table
    typedef struct packed {
        logic     lsuLoad;      // Load when set, store otherwise
        lsuWidthT lsuWidth;
        logic     multiCycle;   // rd written later by the LSU
        logic     aluImm;       // ALU B input takes imm instead of rs2
        aluCatT   aluCat;
        aluOpT    aluOp;
        logic     flagInv;
        logic     pcWriteback;  // Link register write
        pcModeT   pcMode;
    } ctrlWordT;

    localparam ctrlWordT CtrlZero = '0;

    // Register plus immediate add, shared by address and SP arithmetic rows
    localparam ctrlWordT CtrlAddImm = '{
        lsuLoad: 1'b0, lsuWidth: LSN, multiCycle: 1'b0, aluImm: 1'b1,
        aluCat: ADDSUB, aluOp: AFADD, flagInv: 1'b0, pcWriteback: 1'b0, pcMode: PCINC
    };

endpackage

`default_nettype wire

// File: rtl/rvcCtrlIf.sv
`timescale 1ns/1ns
`default_nettype none

interface rvcCtrlIf import rvcDecodePkg::*; ();
    logic     lsuLoad;
    lsuWidthT lsuWidth;
    logic     multiCycle;
    logic     aluImm;
    aluCatT   aluCat;
    aluOpT    aluOp;
    logic     flagInv;
    logic     pcWriteback;
    pcModeT   pcMode;

    modport master (output lsuLoad, lsuWidth, multiCycle, aluImm, aluCat, aluOp,
                    flagInv, pcWriteback, pcMode);
    modport sink   (input  lsuLoad, lsuWidth, multiCycle, aluImm, aluCat, aluOp,
                    flagInv, pcWriteback, pcMode);
endinterface

`default_nettype wire

// File: rtl/rvcClassify.sv
`timescale 1ns/1ns
`default_nettype none

module rvcClassify import rvcDecodePkg::*; (
    input  logic [InstrW-1:0] instr,
    output instrClassT        instrClass
);

    mainOpT     mainOp;
    logic       rs2Zero;
    logic [4:0] rdField;

    // Quadrant bits on top, then funct3[2:1]; quadrant 11 lands on 12..15
    assign mainOp  = mainOpT'({instr[1:0], instr[15:14]});
    assign rs2Zero = ~|instr[6:2];     // Separates MV/ADD from JR/JALR
    assign rdField = instr[11:7];

    always_comb begin
        instrClass = ILLEGAL;          // BAD_2, quadrant 11, anything unmatched
        case (mainOp)
            OP_ADDI4SPN:  instrClass = ADDI4SPN;
            OP_LW:        instrClass = LW;
            OP_SW:        instrClass = SW;
            OP_LWSP:      instrClass = LWSP;
            OP_SWSP:      instrClass = SWSP;
            OP_SLLI:      instrClass = SLLI;
            OP_BEQZ_BNEZ: instrClass = BEQZ_BNEZ; // Bit 13 picks the sense later
            OP_ADDI_NOP_JAL: begin
                instrClass = instr[13] ? JAL : ADDI_NOP;  // NOP is ADDI x0
            end
            OP_LI_LUI_ADDI16SP: begin
                if (!instr[13]) begin
                    instrClass = LI;
                end else if (rdField == 5'(RegSp)) begin
                    instrClass = ADDI16SP;             // LUI encoding with rd x2
                end else begin
                    instrClass = LUI;
                end
            end
            OP_ALUMAIN_J: begin
                if (instr[13]) begin
                    instrClass = J;
                end else begin
                    case (instr[11:10])
                        2'b11:   instrClass = ALUMAIN;  // SUB/XOR/OR/AND
                        2'b10:   instrClass = ANDI;
                        default: instrClass = SRAI_SRLI; // Bit 10 picks arith/logic
                    endcase
                end
            end
            OP_MV_JR_ADD_JALR_EBREAK: begin
                case ({rs2Zero, instr[12]})
                    2'b00:   instrClass = MV;
                    2'b01:   instrClass = ADD;
                    2'b10:   instrClass = JR;
                    default: instrClass = JALR_EBREAK;  // EBREAK when rs1 is x0
                endcase
            end
            default: instrClass = ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rvcRegSelect.sv
`timescale 1ns/1ns
`default_nettype none

module rvcRegSelect import rvcDecodePkg::*; #(
    parameter int RegAddrW = 5
) (
    input  logic [InstrW-1:0]   instr,
    input  instrClassT          instrClass,
    output logic [RegAddrW-1:0] rs1,
    output logic [RegAddrW-1:0] rs2,
    output logic [RegAddrW-1:0] rd
);

    logic [RegAddrW-1:0] bigRs1, bigRs2;
    logic [RegAddrW-1:0] smallRs1, smallRs2;
    logic [RegAddrW-1:0] rawRs1, rawRs2, rawRd;
    logic                useBig;
    logic                rdFromRs2;

    assign bigRs1   = instr[7 +: RegAddrW];              // Full field, top bit dropped at 4
    assign bigRs2   = instr[2 +: RegAddrW];
    assign smallRs1 = RegAddrW'({2'b01, instr[9:7]});    // x8..x15
    assign smallRs2 = RegAddrW'({2'b01, instr[4:2]});

    // Quadrant 10, and quadrant 01 below funct3 100, carry full register fields
    assign useBig    = instr[1] | (instr[0] & ~instr[15]);
    assign rawRs1    = useBig ? bigRs1 : smallRs1;
    assign rawRs2    = useBig ? bigRs2 : smallRs2;
    assign rdFromRs2 = (instrClass == ADDI4SPN) || (instrClass == LW);
    assign rawRd     = rdFromRs2 ? rawRs2 : rawRs1;

    always_comb begin
        rs1 = rawRs1;
        rs2 = rawRs2;
        rd  = rawRd;
        case (instrClass)
            LI, LUI, MV:       rs1 = '0;   // Pass the B operand through an OR
            ADDI4SPN:          rs1 = RegAddrW'(RegSp);
            SWSP: begin
                rs1 = RegAddrW'(RegSp);
                rd  = '0;                  // rs2 is the store data
            end
            J, JR, SW:         rd  = '0;
            JAL, JALR_EBREAK:  rd  = RegAddrW'(RegLink);
            BEQZ_BNEZ: begin
                rs2 = '0;                  // Compare rs1 against x0
                rd  = '0;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rvcImmGen.sv
`timescale 1ns/1ns
`default_nettype none

module rvcImmGen import rvcDecodePkg::*; (
    input  logic [InstrW-1:0] instr,
    input  instrClassT        instrClass,
    output logic [ImmW-1:0]   imm
);

    logic fmtA, fmtB, fmtC, fmtD, fmtE, fmtF, fmtG, fmtH, fmtI, fmtJ;
    logic fmtAI;
    logic signLow;     // Sign fill up to bit 16
    logic signHigh;    // Sign fill above bit 16, LUI included
    logic [InstrW-1:0] i;

    assign i = instr;

    // Format per class
    assign fmtA = (instrClass == ANDI) || (instrClass == ADDI_NOP) || (instrClass == LI);
    assign fmtB = (instrClass == LWSP);
    assign fmtC = (instrClass == J) || (instrClass == JAL);      // 12-bit jump offset
    assign fmtD = (instrClass == BEQZ_BNEZ);
    assign fmtE = (instrClass == ADDI16SP);
    assign fmtF = (instrClass == ADDI4SPN);
    assign fmtG = (instrClass == LW) || (instrClass == SW);
    assign fmtH = (instrClass == SWSP);
    assign fmtI = (instrClass == SRAI_SRLI) || (instrClass == SLLI);
    assign fmtJ = (instrClass == LUI);

    assign fmtAI = fmtA | fmtI;     // Same low bits, only A is signed

    assign signLow  = i[12] & (fmtA | fmtC | fmtD | fmtE);
    assign signHigh = i[12] & (fmtA | fmtC | fmtD | fmtE | fmtJ);

    // Each bit ORs its gated sources
    assign imm[0]  = i[2] & fmtAI;
    assign imm[1]  = i[3] & (fmtAI | fmtC | fmtD);
    assign imm[2]  = (i[4] & (fmtAI | fmtB | fmtC | fmtD)) | (i[9] & fmtH)
                   | (i[6] & (fmtF | fmtG));
    assign imm[3]  = (i[5] & (fmtAI | fmtB | fmtC | fmtF)) | (i[10] & (fmtD | fmtG | fmtH));
    assign imm[4]  = (i[6] & (fmtAI | fmtB | fmtE))
                   | (i[11] & (fmtC | fmtD | fmtF | fmtG | fmtH));
    assign imm[5]  = (i[12] & (fmtAI | fmtB | fmtF | fmtG | fmtH))
                   | (i[2] & (fmtC | fmtD | fmtE));
    assign imm[6]  = (i[12] & fmtA) | (i[5] & (fmtD | fmtE | fmtG)) | (i[2] & fmtB)
                   | (i[7] & (fmtC | fmtF | fmtH));
    assign imm[7]  = (i[12] & fmtA) | (i[6] & (fmtC | fmtD)) | (i[3] & (fmtB | fmtE))
                   | (i[8] & (fmtF | fmtH));
    assign imm[8]  = (i[12] & (fmtA | fmtD)) | (i[4] & fmtE) | (i[9] & (fmtC | fmtF));
    assign imm[9]  = (i[12] & (fmtA | fmtD | fmtE)) | (i[10] & (fmtC | fmtF));
    assign imm[10] = (i[12] & (fmtA | fmtD | fmtE)) | (i[8] & fmtC);
    assign imm[11] = signLow;                           // C keeps its sign here as well

    // LUI field at 16:12, sign of bit 12 fills the rest
    assign imm[16:12]     = fmtJ ? i[6:2] : {5{signLow}};
    assign imm[ImmW-1:17] = {(ImmW - 17){signHigh}};

endmodule

`default_nettype wire

// File: rtl/rvcCtrlLookup.sv
`timescale 1ns/1ns
`default_nettype none

module rvcCtrlLookup import rvcDecodePkg::*; (
    input  logic [InstrW-1:0] instr,
    input  instrClassT        instrClass,
    rvcCtrlIf.master          ctrl
);

    ctrlWordT row;

    always_comb begin
        row = CtrlZero;                        // ILLEGAL and unknown classes
        case (instrClass)
            ALUMAIN: begin
                row.aluCat = aluCatT'({1'b0, ~|instr[6:5]});  // 00 is SUB, rest bitwise
                row.aluOp  = instr[6:5];                     // Direct to ALU opcode
            end
            ANDI: begin
                row.aluImm = 1'b1;
                row.aluOp  = BTAND;            // BITWISE from the zero row
            end
            SRAI_SRLI: begin
                row.aluImm = 1'b1;
                row.aluCat = SHIFT;
                row.aluOp  = instr[10] ? SHSRA : SHSRL;
            end
            SLLI: begin
                row.aluImm = 1'b1;
                row.aluCat = SHIFT;
                row.aluOp  = SHSLL;
            end
            ADDI_NOP, ADDI16SP, ADDI4SPN: row = CtrlAddImm;
            ADD: begin
                row        = CtrlAddImm;
                row.aluImm = 1'b0;             // rd = rs1 + rs2
            end
            LI, LUI: begin
                row.aluImm = 1'b1;
                row.aluOp  = BTOR;             // rs1 is x0, imm passes through
            end
            MV: row.aluOp = BTOR;              // rd = x0 | rs2
            J:  row.pcMode = PCJIMM;           // ALU idle, imm goes to the PC
            JAL: begin
                row.pcMode      = PCJIMM;
                row.pcWriteback = 1'b1;
            end
            JR, JALR_EBREAK: begin
                row.aluCat      = ADDSUB;
                row.aluOp       = AFADD;
                row.pcMode      = PCJREG;
                row.pcWriteback = (instrClass == JALR_EBREAK);  // Link only for JALR
            end
            BEQZ_BNEZ: begin
                row.aluCat  = FLAG;
                row.aluOp   = AFEQU;
                row.flagInv = instr[13];       // BNEZ inverts the equality flag
                row.pcMode  = PCBRCH;
            end
            LW, LWSP: begin
                row            = CtrlAddImm;   // Address is rs1 + imm
                row.lsuLoad    = 1'b1;
                row.lsuWidth   = LSW;
                row.multiCycle = 1'b1;         // rd comes back from the LSU
            end
            SW, SWSP: begin
                row          = CtrlAddImm;
                row.lsuWidth = LSW;            // rs2 still feeds the store data
            end
            default: row = CtrlZero;
        endcase
    end

    assign ctrl.lsuLoad     = row.lsuLoad;
    assign ctrl.lsuWidth    = row.lsuWidth;
    assign ctrl.multiCycle  = row.multiCycle;
    assign ctrl.aluImm      = row.aluImm;
    assign ctrl.aluCat      = row.aluCat;
    assign ctrl.aluOp       = row.aluOp;
    assign ctrl.flagInv     = row.flagInv;
    assign ctrl.pcWriteback = row.pcWriteback;
    assign ctrl.pcMode      = row.pcMode;

endmodule

`default_nettype wire

// File: rtl/rvcDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module rvcDecoder import rvcDecodePkg::*; #(
    parameter int RegAddrW = 5          // 4 for the embedded register file
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                inVld,
    input  logic [InstrW-1:0]   instr,
    output logic                outVld,
    output logic [RegAddrW-1:0] rs1,
    output logic [RegAddrW-1:0] rs2,
    output logic [RegAddrW-1:0] rd,
    output logic [ImmW-1:0]     imm,
    output logic                lsuLoad,
    output lsuWidthT            lsuWidth,
    output logic                multiCycle,
    output logic                aluImm,
    output aluCatT              aluCat,
    output aluOpT               aluOp,
    output logic                flagInv,
    output logic                pcWriteback,
    output pcModeT              pcMode
);

    instrClassT          instrClass;
    logic [RegAddrW-1:0] rs1Comb, rs2Comb, rdComb;
    logic [ImmW-1:0]     immComb;

    rvcCtrlIf ctrlBus ();

    rvcClassify uClassify (.instr(instr), .instrClass(instrClass));

    rvcRegSelect #(.RegAddrW(RegAddrW)) uRegSelect (
        .instr      (instr),
        .instrClass (instrClass),
        .rs1        (rs1Comb),
        .rs2        (rs2Comb),
        .rd         (rdComb)
    );

    rvcImmGen uImmGen (.instr(instr), .instrClass(instrClass), .imm(immComb));

    rvcCtrlLookup uCtrlLookup (.instr(instr), .instrClass(instrClass), .ctrl(ctrlBus.master));

    // Decode stage register loads every cycle whatever inVld says
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outVld      <= 1'b0;
            rs1         <= '0;
            rs2         <= '0;
            rd          <= '0;
            imm         <= '0;
            lsuLoad     <= 1'b0;
            lsuWidth    <= LSN;
            multiCycle  <= 1'b0;
            aluImm      <= 1'b0;
            aluCat      <= BITWISE;
            aluOp       <= '0;
            flagInv     <= 1'b0;
            pcWriteback <= 1'b0;
            pcMode      <= PCINC;
        end else begin
            outVld      <= inVld;       // Marks which cycles carry a real decode
            rs1         <= rs1Comb;
            rs2         <= rs2Comb;
            rd          <= rdComb;
            imm         <= immComb;
            lsuLoad     <= ctrlBus.lsuLoad;
            lsuWidth    <= ctrlBus.lsuWidth;
            multiCycle  <= ctrlBus.multiCycle;
            aluImm      <= ctrlBus.aluImm;
            aluCat      <= ctrlBus.aluCat;
            aluOp       <= ctrlBus.aluOp;
            flagInv     <= ctrlBus.flagInv;
            pcWriteback <= ctrlBus.pcWriteback;
            pcMode      <= ctrlBus.pcMode;
        end
    end

endmodule

`default_nettype wire

// File: tests/rvcDecoderTb.sv
`timescale 1ns/1ns
`default_nettype none

module rvcDecoderTb import rvcDecodePkg::*; ();

    localparam int ResetCycles = 8;
    localparam int NumDecodes  = 42;                             // Decode and idle cycles, spare
    localparam int CycleLimit  = 4 * (ResetCycles + NumDecodes); // 200 cycles
    localparam int Dc          = -1;                             // Register left unchecked

    // Expected control rows {lsuLoad, lsuWidth, multiCycle, aluImm, aluCat, aluOp,
    // flagInv, pcWriteback, pcMode}
    localparam logic [12:0] AddImmRow = {1'b0, LSN, 1'b0, 1'b1, ADDSUB, AFADD, 2'b00, PCINC};
    localparam logic [12:0] AddRegRow = {1'b0, LSN, 1'b0, 1'b0, ADDSUB, AFADD, 2'b00, PCINC};
    localparam logic [12:0] ImmOrRow  = {1'b0, LSN, 1'b0, 1'b1, BITWISE, BTOR, 2'b00, PCINC};
    localparam logic [12:0] LoadRow   = {1'b1, LSW, 1'b1, 1'b1, ADDSUB, AFADD, 2'b00, PCINC};
    localparam logic [12:0] StoreRow  = {1'b0, LSW, 1'b0, 1'b1, ADDSUB, AFADD, 2'b00, PCINC};
    localparam logic [12:0] BranchRow = {1'b0, LSN, 1'b0, 1'b0, FLAG, AFEQU, 2'b00, PCBRCH};
    localparam logic [12:0] JregRow   = {1'b0, LSN, 1'b0, 1'b0, ADDSUB, AFADD, 2'b00, PCJREG};
    localparam logic [12:0] JimmRow   = {1'b0, LSN, 1'b0, 1'b0, BITWISE, 2'd0, 2'b00, PCJIMM};

    logic        clk = 1'b0;
    logic        rstN, inVld, outVld;
    logic [15:0] instr;
    logic [4:0]  rs1, rs2, rd;
    logic [31:0] imm;
    logic        lsuLoad, multiCycle, aluImm, flagInv, pcWriteback;
    lsuWidthT    lsuWidth;
    aluCatT      aluCat;
    aluOpT       aluOp;
    pcModeT      pcMode;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    rvcDecoder #(.RegAddrW(5)) rvcDecoder_inst (
        .clk(clk), .rstN(rstN), .inVld(inVld), .instr(instr), .outVld(outVld),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .lsuLoad(lsuLoad), .lsuWidth(lsuWidth), .multiCycle(multiCycle), .aluImm(aluImm),
        .aluCat(aluCat), .aluOp(aluOp), .flagInv(flagInv),
        .pcWriteback(pcWriteback), .pcMode(pcMode)
    );

    always #20 clk = ~clk;  // 40 ns period

    // RVC encoders following the compressed ISA bit placement
    function automatic logic [15:0] encCi(input logic [2:0] f3, input logic [4:0] r,
                                          input logic [5:0] v, input logic [1:0] q);
        return {f3, v[5], r, v[4:0], q};
    endfunction
    function automatic logic [15:0] encCa(input logic [1:0] f2, input logic [2:0] rdp,
                                          input logic [2:0] rs2p);
        return {6'b100011, rdp, f2, rs2p, 2'b01};
    endfunction
    function automatic logic [15:0] encCr(input logic [3:0] f4, input logic [4:0] r1,
                                          input logic [4:0] r2);
        return {f4, r1, r2, 2'b10};
    endfunction
    function automatic logic [15:0] encCj(input logic [2:0] f3, input logic [11:0] o);
        return {f3, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
    endfunction
    function automatic logic [15:0] encCb(input logic [2:0] f3, input logic [2:0] rp,
                                          input logic [8:0] o);
        return {f3, o[8], o[4:3], rp, o[7:6], o[2:1], o[5], 2'b01};
    endfunction
    function automatic logic [15:0] encCl(input logic [2:0] f3, input logic [2:0] basep,
                                          input logic [2:0] datap, input logic [6:0] o);
        return {f3, o[5:3], basep, o[2], o[6], datap, 2'b00};
    endfunction
    function automatic logic [15:0] encLwsp(input logic [4:0] r, input logic [7:0] o);
        return {3'b010, o[5], r, o[4:2], o[7:6], 2'b10};
    endfunction
    function automatic logic [15:0] encSwsp(input logic [4:0] r, input logic [7:0] o);
        return {3'b110, o[5:2], o[7:6], r, 2'b10};
    endfunction
    function automatic logic [15:0] encAddi4spn(input logic [2:0] rdp, input logic [9:0] o);
        return {3'b000, o[5:4], o[9:6], o[2], o[3], rdp, 2'b00};
    endfunction
    function automatic logic [15:0] encAddi16sp(input logic [9:0] o);
        return {3'b011, o[9], 5'd2, o[4], o[6], o[8:7], o[5], 2'b01};
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s = 0x%h, expected 0x%h",
                     $time, name, actual, expected);
        end
    endtask

    // Drive on the falling edge, check one rising edge later
    task automatic runDecode(input string name, input logic [15:0] ins,
                             input int eRs1, input int eRs2, input int eRd,
                             input logic [31:0] eImm, input logic [12:0] eCtrl);
        inVld = 1'b1;
        instr = ins;
        @(negedge clk);
        compare({name, " outVld"}, 32'(outVld), 32'd1);
        if (eRs1 != Dc) compare({name, " rs1"}, 32'(rs1), eRs1);
        if (eRs2 != Dc) compare({name, " rs2"}, 32'(rs2), eRs2);
        if (eRd != Dc) compare({name, " rd"}, 32'(rd), eRd);
        compare({name, " imm"}, imm, eImm);
        compare({name, " ctrl"}, 32'({lsuLoad, lsuWidth, multiCycle, aluImm, aluCat, aluOp,
                                      flagInv, pcWriteback, pcMode}), 32'(eCtrl));
    endtask

    task automatic testResetPipeline();
        repeat (ResetCycles) @(negedge clk);
        compare("reset outVld", 32'(outVld), 32'd0);
        compare("reset regs", 32'({rs1, rs2, rd}), 32'd0);
        compare("reset imm", imm, 32'd0);
        compare("reset ctrl", 32'({lsuLoad, lsuWidth, multiCycle, aluImm, aluCat, aluOp,
                                   flagInv, pcWriteback, pcMode}), 32'd0);
        rstN = 1'b1;
        @(negedge clk);                                      // inVld still low
        compare("idle outVld", 32'(outVld), 32'd0);
        runDecode("pipe C.ADDI", encCi(3'b000, 5'd1, 6'd1, 2'b01), 1, Dc, 1, 1, AddImmRow);
        runDecode("pipe C.LI", encCi(3'b010, 5'd2, 6'(-1), 2'b01), 0, Dc, 2, -1, ImmOrRow);
        runDecode("pipe C.ADD", encCr(4'b1001, 5'd3, 5'd4), 3, 4, 3, 0, AddRegRow);
        inVld = 1'b0;
        instr = encCi(3'b010, 5'd9, 6'd1, 2'b01);            // C.LI x9 waits at the input
        #10;                                                 // Half way to the rising edge
        compare("hold outVld", 32'(outVld), 32'd1);          // Register still shows C.ADD
        compare("hold rs1", 32'(rs1), 32'd3);
        compare("hold rs2", 32'(rs2), 32'd4);
        @(negedge clk);
        compare("gap outVld", 32'(outVld), 32'd0);
    endtask

    task automatic testRegAlu();
        runDecode("C.SUB", encCa(2'b00, 3'd1, 3'd2), 9, 10, 9, 0,
                  {1'b0, LSN, 1'b0, 1'b0, ADDSUB, AFSUBS, 2'b00, PCINC});
        runDecode("C.XOR", encCa(2'b01, 3'd3, 3'd4), 11, 12, 11, 0,
                  {1'b0, LSN, 1'b0, 1'b0, BITWISE, BTXOR, 2'b00, PCINC});
        runDecode("C.OR", encCa(2'b10, 3'd5, 3'd6), 13, 14, 13, 0,
                  {1'b0, LSN, 1'b0, 1'b0, BITWISE, BTOR, 2'b00, PCINC});
        runDecode("C.AND", encCa(2'b11, 3'd7, 3'd0), 15, 8, 15, 0,
                  {1'b0, LSN, 1'b0, 1'b0, BITWISE, BTAND, 2'b00, PCINC});
        runDecode("C.MV", encCr(4'b1000, 5'd20, 5'd17), 0, 17, 20, 0,
                  {1'b0, LSN, 1'b0, 1'b0, BITWISE, BTOR, 2'b00, PCINC});
        runDecode("C.ADD", encCr(4'b1001, 5'd6, 5'd31), 6, 31, 6, 0, AddRegRow);
    endtask

    task automatic testImmAlu();
        runDecode("C.ADDI", encCi(3'b000, 5'd10, 6'(-5), 2'b01), 10, Dc, 10, -5, AddImmRow);
        runDecode("C.LI", encCi(3'b010, 5'd11, 6'd17, 2'b01), 0, Dc, 11, 17, ImmOrRow);
        runDecode("C.LI neg", encCi(3'b010, 5'd9, 6'(-32), 2'b01), 0, Dc, 9, -32, ImmOrRow);
        runDecode("C.LUI", encCi(3'b011, 5'd12, 6'h21, 2'b01), 0, Dc, 12, -31 * 4096,
                  ImmOrRow);                                // Field 100001 is -31
        runDecode("C.LUI pos", encCi(3'b011, 5'd30, 6'h05, 2'b01), 0, Dc, 30, 5 * 4096,
                  ImmOrRow);
        runDecode("C.ANDI", {3'b100, 1'b1, 2'b10, 3'd3, 5'b11100, 2'b01}, 11, Dc, 11, -4,
                  {1'b0, LSN, 1'b0, 1'b1, BITWISE, BTAND, 2'b00, PCINC});
        runDecode("C.SLLI", encCi(3'b000, 5'd5, 6'd7, 2'b10), 5, Dc, 5, 7,
                  {1'b0, LSN, 1'b0, 1'b1, SHIFT, SHSLL, 2'b00, PCINC});
        runDecode("C.SRLI", {3'b100, 1'b0, 2'b00, 3'd4, 5'd31, 2'b01}, 12, Dc, 12, 31,
                  {1'b0, LSN, 1'b0, 1'b1, SHIFT, SHSRL, 2'b00, PCINC});
        runDecode("C.SRAI", {3'b100, 1'b1, 2'b01, 3'd5, 5'd9, 2'b01}, 13, Dc, 13, 41,
                  {1'b0, LSN, 1'b0, 1'b1, SHIFT, SHSRA, 2'b00, PCINC});  // Bit 12 not a sign
        runDecode("C.ADDI16SP", encAddi16sp(10'(-64)), 2, Dc, 2, -64, AddImmRow);
        runDecode("C.ADDI16SP pos", encAddi16sp(10'd496), 2, Dc, 2, 496, AddImmRow);
        runDecode("C.ADDI4SPN", encAddi4spn(3'd3, 10'd596), 2, Dc, 11, 596, AddImmRow);
    endtask

    task automatic testLoadStore();
        runDecode("C.LW", encCl(3'b010, 3'd2, 3'd5, 7'd84), 10, Dc, 13, 84, LoadRow);
        runDecode("C.SW", encCl(3'b110, 3'd1, 3'd6, 7'd68), 9, 14, 0, 68, StoreRow);
        runDecode("C.LWSP", encLwsp(5'd7, 8'd164), Dc, Dc, 7, 164, LoadRow);
        runDecode("C.SWSP", encSwsp(5'd25, 8'd200), 2, 25, 0, 200, StoreRow);
    endtask

    task automatic testControlFlow();
        runDecode("C.J", encCj(3'b101, 12'(-2048)), Dc, Dc, 0, -2048, JimmRow);
        runDecode("C.J pos", encCj(3'b101, 12'd1234), Dc, Dc, 0, 1234, JimmRow);
        runDecode("C.JAL", encCj(3'b001, 12'd682), Dc, Dc, 1, 682, JimmRow | 13'h004);
        runDecode("C.JR", encCr(4'b1000, 5'd9, 5'd0), 9, Dc, 0, 0, JregRow);
        runDecode("C.JALR", encCr(4'b1001, 5'd14, 5'd0), 14, Dc, 1, 0, JregRow | 13'h004);
        runDecode("C.BEQZ", encCb(3'b110, 3'd4, 9'(-256)), 12, 0, 0, -256, BranchRow);
        runDecode("C.BNEZ", encCb(3'b111, 3'd0, 9'd170), 8, 0, 0, 170,
                  BranchRow | 13'h008);                     // flagInv set
    endtask

    task automatic testIllegal();
        runDecode("BAD_2", 16'hA5A4, Dc, Dc, Dc, 0, 13'd0);  // Quadrant 00, funct3 101
        runDecode("Q3 all ones", 16'hFFFF, Dc, Dc, Dc, 0, 13'd0);
        runDecode("Q3 low", 16'h0003, Dc, Dc, Dc, 0, 13'd0);
        inVld = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rstN  = 1'b0;
        inVld = 1'b0;
        instr = '0;
        testResetPipeline();
        testRegAlu();
        testImmAlu();
        testLoadStore();
        testControlFlow();
        testIllegal();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rvcDecoder.f
rtl/rvcDecodePkg.sv
rtl/rvcCtrlIf.sv
rtl/rvcClassify.sv
rtl/rvcRegSelect.sv
rtl/rvcImmGen.sv
rtl/rvcCtrlLookup.sv
rtl/rvcDecoder.sv
tests/rvcDecoderTb.sv

// File: runSim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ns --top-module rvcDecoderTb \
    -f rvcDecoder.f -o simv \
    && ./obj_dir/simv | tee sim.log \
    && grep -qx "TEST PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
